// File: sa_pe.f
hdl/sa_pe_pkg.sv
hdl/pe_zero_gate.sv
hdl/pe_multiplier.sv
hdl/pe_accumulator.sv
hdl/pe_propagate.sv
hdl/sa_pe.sv
sim/tb_sa_pe.sv

// File: sim/pe_stimulus.txt
// Inputs: a b c thres cell_en cell_sc_en pipeline_en cswitch cscan_en reg_clear
// Expected after the next edge: o_a o_b o_c o_cswitch o_cell_en (all hex)
// Reset state, then propagation and a signed stream
0000 0000 000000000000 0 0 0 0 0 0 0 0000 0000 000000000000 0 0
0003 0005 000000000000 0 1 1 1 0 0 0 0003 0005 000000000000 0 1
fffe 0007 000000000000 0 1 0 1 0 0 0 fffe 0007 000000000000 0 1
0064 fffd 000000000000 0 1 0 1 0 0 0 0064 fffd 000000000000 0 1
8000 7fff 000000000000 0 1 0 1 0 0 0 8000 7fff 000000000000 0 1
0000 0000 000000000000 0 1 0 1 0 0 0 0000 0000 000000000000 0 1
0000 0000 000000000000 0 1 0 1 0 0 0 0000 0000 000000000000 0 1
0000 0000 000000000000 0 1 0 1 0 0 0 0000 0000 000000000000 0 1
0000 0000 000000000000 0 1 0 1 0 0 0 0000 0000 000000000000 0 1
// Context switch moves the sum to the scan register
0000 0000 000000000000 0 1 0 1 1 0 0 0000 0000 ffffc0007ed5 1 1
// Preload shift, negligible pairs and a two cycle stall
0004 0005 0000000003e8 0 1 0 1 0 1 0 0004 0005 0000000003e8 0 1
0003 0009 000000000000 2 1 0 1 0 0 0 0003 0009 0000000003e8 0 1
0001 ffff 000000000000 0 1 0 1 0 0 0 0001 ffff 0000000003e8 0 1
0007 0006 000000000000 3 1 0 0 0 0 0 0001 ffff 0000000003e8 0 1
0007 0006 000000000000 3 1 0 0 0 0 0 0001 ffff 0000000003e8 0 1
0007 0006 000000000000 3 1 0 1 0 0 0 0007 0006 0000000003e8 0 1
0006 0002 000000000000 1 1 0 1 0 0 0 0006 0002 0000000003e8 0 1
0010 0001 000000000000 1 1 0 1 0 0 0 0010 0001 0000000003e8 0 1
0000 1234 000000000000 0 1 0 1 0 0 0 0000 1234 0000000003e8 0 1
0000 0000 000000000000 0 1 0 1 0 0 0 0000 0000 0000000003e8 0 1
// Switch with a live product starts the next sum from the preload
0000 0000 000000000000 0 1 0 1 1 0 0 0000 0000 000000000013 1 1
// Disabled cell keeps scanning, cell enable chain shifts
1111 2222 000000000055 0 0 0 1 0 1 0 0000 0000 000000000055 1 1
1111 2222 ffffffffff00 0 0 1 1 0 1 0 0000 0000 ffffffffff00 1 0
0002 0003 000000000000 0 1 1 1 0 0 0 0002 0003 ffffffffff00 0 1
0000 0000 000000000777 0 1 0 0 0 1 0 0002 0003 ffffffffff00 0 1
0000 0000 000000000000 0 1 0 1 0 0 0 0000 0000 ffffffffff00 0 1
0000 0000 000000000000 0 1 0 1 0 0 0 0000 0000 ffffffffff00 0 1
0000 0000 000000000000 0 1 0 1 0 0 0 0000 0000 ffffffffff00 0 1
0000 0000 000000000000 0 1 0 1 0 0 0 0000 0000 ffffffffff00 0 1
// Flagged pair on the switch adds nothing
0000 0000 000000000000 0 1 0 1 1 0 0 0000 0000 0000000003fa 1 1
// Synchronous clear, then a switch shows the cleared accumulator
1234 5678 000000000abc 0 1 1 1 0 1 1 0000 0000 000000000000 0 0
0000 0000 000000000000 0 1 0 1 1 0 0 0000 0000 000000000000 1 0
0000 0000 000000000000 0 1 0 1 0 0 0 0000 0000 000000000000 0 0

// File: sim/tb_sa_pe.sv
`timescale 1ns/1ps

module tb_sa_pe;

    // Words per vector line in the stimulus file
    localparam int NUM_FIELDS  = 15;
    localparam int MAX_VECTORS = 64;
    localparam int CLK_PERIOD  = 8;
    localparam int RST_CYCLES  = 3;
    localparam STIM_FILE = "sim/pe_stimulus.txt";

    // DUT inputs
    logic                           i_clk;
    logic                           i_rstn;
    logic                           i_reg_clear;
    logic                           i_cell_en;
    logic                           i_cell_sc_en;
    logic                           i_pipeline_en;
    logic                           i_cswitch;
    logic                           i_cscan_en;
    logic [sa_pe_pkg::A_W-1:0]      i_a;
    logic [sa_pe_pkg::B_W-1:0]      i_b;
    logic [sa_pe_pkg::ACC_W-1:0]    i_c;
    logic [sa_pe_pkg::TH_W-1:0]     i_thres;

    // DUT outputs
    logic [sa_pe_pkg::A_W-1:0]      o_a;
    logic [sa_pe_pkg::B_W-1:0]      o_b;
    logic [sa_pe_pkg::ACC_W-1:0]    o_c;
    logic                           o_cswitch;
    logic                           o_cell_en;

    // Whole stimulus file, one word per field
    logic [sa_pe_pkg::ACC_W-1:0] stim_mem [NUM_FIELDS*MAX_VECTORS];
    int                          vec_count;
    int unsigned                 seed_ret;

    sa_pe i_sa_pe (
        .i_clk         (i_clk),
        .i_rstn        (i_rstn),
        .i_reg_clear   (i_reg_clear),
        .i_cell_en     (i_cell_en),
        .i_cell_sc_en  (i_cell_sc_en),
        .i_pipeline_en (i_pipeline_en),
        .i_cswitch     (i_cswitch),
        .i_cscan_en    (i_cscan_en),
        .i_a           (i_a),
        .i_b           (i_b),
        .i_c           (i_c),
        .i_thres       (i_thres),
        .o_a           (o_a),
        .o_b           (o_b),
        .o_c           (o_c),
        .o_cswitch     (o_cswitch),
        .o_cell_en     (o_cell_en)
    );

    // ------------------------------------------------------------
    // Clock
    // ------------------------------------------------------------

    always #(CLK_PERIOD/2) i_clk = ~i_clk;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    // Read the vector file and count the complete lines
    task automatic load_vectors();
        int fd;
        int n;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file %s", STIM_FILE);
            $display("Test failed");
            $fatal(1, "stimulus file missing");
        end
        $fclose(fd);
        $readmemh(STIM_FILE, stim_mem);
        // Unloaded words stay unknown, so the first one ends the list
        n = 0;
        while (n < MAX_VECTORS && !$isunknown(stim_mem[n*NUM_FIELDS])) begin
            n++;
        end
        if (n == 0) begin
            $display("the stimulus file %s holds no vectors", STIM_FILE);
            $display("Test failed");
            $fatal(1, "stimulus file empty");
        end
        vec_count = n;
    endtask

    // Drive one vector
    // i_c is only meaningful while scanning
    task automatic apply_vector(input int k);
        int          base;
        logic [31:0] r_lo;
        logic [31:0] r_hi;
        base = k * NUM_FIELDS;
        r_lo = $urandom();
        r_hi = $urandom();
        i_a           <= stim_mem[base + 0][sa_pe_pkg::A_W-1:0];
        i_b           <= stim_mem[base + 1][sa_pe_pkg::B_W-1:0];
        i_thres       <= stim_mem[base + 3][sa_pe_pkg::TH_W-1:0];
        i_cell_en     <= stim_mem[base + 4][0];
        i_cell_sc_en  <= stim_mem[base + 5][0];
        i_pipeline_en <= stim_mem[base + 6][0];
        i_cswitch     <= stim_mem[base + 7][0];
        i_cscan_en    <= stim_mem[base + 8][0];
        i_reg_clear   <= stim_mem[base + 9][0];
        if (stim_mem[base + 8][0]) begin
            i_c <= stim_mem[base + 2];
        end else begin
            // Idle neighbour value that is never sampled
            i_c <= {r_hi[15:0], r_lo};
        end
    endtask

    task automatic check_value(input string name, input int k,
                               input logic [sa_pe_pkg::ACC_W-1:0] got,
                               input logic [sa_pe_pkg::ACC_W-1:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0d ns: vector %0d %s expected %h got %h",
                     $time, k, name, expected, got);
            $display("Test failed");
            $fatal(1, "first error reached");
        end
    endtask

    // Compare all outputs after the edge that took vector k
    task automatic check_outputs(input int k);
        int base;
        base = k * NUM_FIELDS;
        check_value("o_a", k, o_a, stim_mem[base + 10]);
        check_value("o_b", k, o_b, stim_mem[base + 11]);
        check_value("o_c", k, o_c, stim_mem[base + 12]);
        check_value("o_cswitch", k, o_cswitch, stim_mem[base + 13]);
        check_value("o_cell_en", k, o_cell_en, stim_mem[base + 14]);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        i_clk         = 1'b0;
        i_rstn        = 1'b0;
        i_reg_clear   = 1'b0;
        i_cell_en     = 1'b0;
        i_cell_sc_en  = 1'b0;
        i_pipeline_en = 1'b0;
        i_cswitch     = 1'b0;
        i_cscan_en    = 1'b0;
        i_a           = '0;
        i_b           = '0;
        i_c           = '0;
        i_thres       = '0;
        vec_count     = 0;
        seed_ret      = $urandom(32'ha93a5d41);
        load_vectors();

        repeat (RST_CYCLES) @(posedge i_clk);
        i_rstn <= 1'b1;

        @(posedge i_clk);
        apply_vector(0);
        // Next vector goes in on the edge that samples this one
        // Outputs are compared half a period later
        for (int k = 0; k < vec_count; k++) begin
            @(posedge i_clk);
            if (k + 1 < vec_count) begin
                apply_vector(k + 1);
            end
            @(negedge i_clk);
            check_outputs(k);
        end

        $display("Test passed");
        $finish;
    end

    // ------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------

    // Twice the vector time plus reset
    initial begin
        wait (vec_count > 0);
        #((2 * vec_count * CLK_PERIOD) + (RST_CYCLES * CLK_PERIOD));
        $display("timeout: %0d vectors did not finish in time", vec_count);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: hdl/sa_pe.sv
`timescale 1ns/1ps

module sa_pe (
    input  logic                           i_clk,
    input  logic                           i_rstn,
    input  logic                           i_reg_clear,
    input  logic                           i_cell_en,
    input  logic                           i_cell_sc_en,
    input  logic                           i_pipeline_en,
    input  logic                           i_cswitch,
    input  logic                           i_cscan_en,
    input  logic [sa_pe_pkg::A_W-1:0]      i_a,
    input  logic [sa_pe_pkg::B_W-1:0]      i_b,
    input  logic [sa_pe_pkg::ACC_W-1:0]    i_c,
    input  logic [sa_pe_pkg::TH_W-1:0]     i_thres,
    output logic [sa_pe_pkg::A_W-1:0]      o_a,
    output logic [sa_pe_pkg::B_W-1:0]      o_b,
    output logic [sa_pe_pkg::ACC_W-1:0]    o_c,
    output logic                           o_cswitch,
    output logic                           o_cell_en
);

    // Common stage enable
    logic                         stage_en;

    // Zero gate to multiplier
    logic [sa_pe_pkg::A_W-1:0]    a_gated;
    logic [sa_pe_pkg::B_W-1:0]    b_gated;
    logic                         zero_s0;

    // Multiplier to accumulator
    logic [sa_pe_pkg::PROD_W-1:0] prod;
    logic                         zero_s2;

    // ------------------------------------------------------------
    // Stage enable
    // ------------------------------------------------------------

    // A disabled cell or a global stall freezes all stages at once
    assign stage_en = i_cell_en & i_pipeline_en;

    // ------------------------------------------------------------
    // Compute pipeline
    // ------------------------------------------------------------

    // Stage 0, zero detection and operand gating
    pe_zero_gate i_pe_zero_gate (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_reg_clear (i_reg_clear),
        .i_en        (stage_en),
        .i_a         (i_a),
        .i_b         (i_b),
        .i_thres     (i_thres),
        .o_a_gated   (a_gated),
        .o_b_gated   (b_gated),
        .o_zero      (zero_s0)
    );

    // Stage 1, pipelined multiplier with flag shimming
    pe_multiplier i_pe_multiplier (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_reg_clear (i_reg_clear),
        .i_en        (stage_en),
        .i_zero      (zero_s0),
        .i_a         (a_gated),
        .i_b         (b_gated),
        .o_prod      (prod),
        .o_zero      (zero_s2)
    );

    // Stage 2, accumulate and output scan chain
    pe_accumulator i_pe_accumulator (
        .i_clk         (i_clk),
        .i_rstn        (i_rstn),
        .i_reg_clear   (i_reg_clear),
        .i_en          (stage_en),
        .i_pipeline_en (i_pipeline_en),
        .i_zero        (zero_s2),
        .i_cswitch     (i_cswitch),
        .i_cscan_en    (i_cscan_en),
        .i_prod        (prod),
        .i_c           (i_c),
        .o_c           (o_c)
    );

    // ------------------------------------------------------------
    // Neighbour propagation
    // ------------------------------------------------------------

    pe_propagate i_pe_propagate (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_reg_clear  (i_reg_clear),
        .i_en         (stage_en),
        .i_cswitch    (i_cswitch),
        .i_cell_en    (i_cell_en),
        .i_cell_sc_en (i_cell_sc_en),
        .i_a          (i_a),
        .i_b          (i_b),
        .o_a          (o_a),
        .o_b          (o_b),
        .o_cswitch    (o_cswitch),
        .o_cell_en    (o_cell_en)
    );

endmodule

// File: hdl/pe_propagate.sv
`timescale 1ns/1ps

module pe_propagate (
    input  logic                           i_clk,
    input  logic                           i_rstn,
    input  logic                           i_reg_clear,
    input  logic                           i_en,
    input  logic                           i_cswitch,
    input  logic                           i_cell_en,
    input  logic                           i_cell_sc_en,
    input  logic [sa_pe_pkg::A_W-1:0]      i_a,
    input  logic [sa_pe_pkg::B_W-1:0]      i_b,
    output logic [sa_pe_pkg::A_W-1:0]      o_a,
    output logic [sa_pe_pkg::B_W-1:0]      o_b,
    output logic                           o_cswitch,
    output logic                           o_cell_en
);

    // ------------------------------------------------------------
    // Operand and context switch forwarding
    // ------------------------------------------------------------

    // One enabled cycle of delay toward the neighbouring cells,
    // frozen together with the local pipeline
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_a       <= '0;
            o_b       <= '0;
            o_cswitch <= 1'b0;
        end else if (i_reg_clear) begin
            o_a       <= '0;
            o_b       <= '0;
            o_cswitch <= 1'b0;
        end else if (i_en) begin
            o_a       <= i_a;
            o_b       <= i_b;
            o_cswitch <= i_cswitch;
        end
    end

    // ------------------------------------------------------------
    // Cell enable scan chain
    // ------------------------------------------------------------

    // Shifts on its own strobe, independent of the stage enable
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_cell_en <= 1'b0;
        end else if (i_reg_clear) begin
            o_cell_en <= 1'b0;
        end else if (i_cell_sc_en) begin
            o_cell_en <= i_cell_en;
        end
    end

endmodule

// File: hdl/pe_accumulator.sv
`timescale 1ns/1ps

module pe_accumulator (
    input  logic                           i_clk,
    input  logic                           i_rstn,
    input  logic                           i_reg_clear,
    input  logic                           i_en,
    input  logic                           i_pipeline_en,
    input  logic                           i_zero,
    input  logic                           i_cswitch,
    input  logic                           i_cscan_en,
    input  logic [sa_pe_pkg::PROD_W-1:0]   i_prod,
    input  logic [sa_pe_pkg::ACC_W-1:0]    i_c,
    output logic [sa_pe_pkg::ACC_W-1:0]    o_c
);

    // Running sum of the current context
    logic [sa_pe_pkg::ACC_W-1:0]  acc_q;
    // Output scan register, also holds the next preload
    logic [sa_pe_pkg::ACC_W-1:0]  scan_q;
    logic [sa_pe_pkg::ACC_W-1:0]  scan_d;
    logic                         scan_en;

    // Adder operands and result
    logic [sa_pe_pkg::PROD_W-1:0] prod_term;
    logic [sa_pe_pkg::ACC_W-1:0]  prod_ext;
    logic [sa_pe_pkg::ACC_W-1:0]  acc_term;
    logic [sa_pe_pkg::ACC_W-1:0]  acc_sum;
    logic                         acc_we;

    // ------------------------------------------------------------
    // Adder input selection
    // ------------------------------------------------------------

    // A flagged product cannot be skipped during a context switch,
    // since the accumulator must load anyway; force it to zero
    assign prod_term = (i_zero && i_cswitch) ? '0 : i_prod;

    // Sign extension of the product up to accumulator width
    assign prod_ext = {{(sa_pe_pkg::ACC_W - sa_pe_pkg::PROD_W){prod_term[sa_pe_pkg::PROD_W-1]}},
                       prod_term};

    // On a switch, start the new sum from the preload in the scan reg
    assign acc_term = i_cswitch ? scan_q : acc_q;

    assign acc_sum = prod_ext + acc_term;

    // Skip the write for a negligible product, unless switching
    assign acc_we = i_en & (i_cswitch | ~i_zero);

    // ------------------------------------------------------------
    // Accumulator register
    // ------------------------------------------------------------

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            acc_q <= '0;
        end else if (i_reg_clear) begin
            acc_q <= '0;
        end else if (acc_we) begin
            acc_q <= acc_sum;
        end
    end

    // ------------------------------------------------------------
    // Output scan register
    // ------------------------------------------------------------

    // Only the global pipeline enable gates the scan chain,
    // so results keep shifting through a disabled cell
    assign scan_en = (i_cscan_en | i_cswitch) & i_pipeline_en;

    // Finished sum on a switch, neighbour's value otherwise
    assign scan_d = i_cswitch ? acc_q : i_c;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            scan_q <= '0;
        end else if (i_reg_clear) begin
            scan_q <= '0;
        end else if (scan_en) begin
            scan_q <= scan_d;
        end
    end

    // Scan chain output toward the next cell
    assign o_c = scan_q;

endmodule

// File: hdl/pe_multiplier.sv
`timescale 1ns/1ps

module pe_multiplier (
    input  logic                           i_clk,
    input  logic                           i_rstn,
    input  logic                           i_reg_clear,
    input  logic                           i_en,
    input  logic                           i_zero,
    input  logic [sa_pe_pkg::A_W-1:0]      i_a,
    input  logic [sa_pe_pkg::B_W-1:0]      i_b,
    output logic [sa_pe_pkg::PROD_W-1:0]   o_prod,
    output logic                           o_zero
);

    // Raw signed product
    logic signed [sa_pe_pkg::PROD_W-1:0] prod_d;
    // Internal multiplier pipeline
    logic signed [sa_pe_pkg::PROD_W-1:0] prod_pipe [sa_pe_pkg::MUL_STAGES];
    // Zero flag shimming chain, one bit per multiplier stage
    logic [sa_pe_pkg::MUL_STAGES-1:0]    zero_shim;

    // ------------------------------------------------------------
    // Signed multiply
    // ------------------------------------------------------------

    // Both operands are two's complement
    assign prod_d = $signed(i_a) * $signed(i_b);

    // ------------------------------------------------------------
    // Multiplier stages and flag shimming
    // ------------------------------------------------------------

    // Product and flag advance in lockstep, so a flag never
    // drifts away from the pair that raised it
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            for (int i = 0; i < sa_pe_pkg::MUL_STAGES; i++) begin
                prod_pipe[i] <= '0;
            end
            zero_shim <= '0;
        end else if (i_reg_clear) begin
            for (int i = 0; i < sa_pe_pkg::MUL_STAGES; i++) begin
                prod_pipe[i] <= '0;
            end
            zero_shim <= '0;
        end else if (i_en) begin
            prod_pipe[0] <= prod_d;
            zero_shim[0] <= i_zero;
            // Remaining stages just shift
            for (int i = 1; i < sa_pe_pkg::MUL_STAGES; i++) begin
                prod_pipe[i] <= prod_pipe[i-1];
                zero_shim[i] <= zero_shim[i-1];
            end
        end
    end

    // ------------------------------------------------------------
    // Intermediate register between multiply and add
    // ------------------------------------------------------------

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_prod <= '0;
            o_zero <= 1'b0;
        end else if (i_reg_clear) begin
            o_prod <= '0;
            o_zero <= 1'b0;
        end else if (i_en) begin
            o_prod <= prod_pipe[sa_pe_pkg::MUL_STAGES-1];
            o_zero <= zero_shim[sa_pe_pkg::MUL_STAGES-1];
        end
    end

endmodule

// File: hdl/pe_zero_gate.sv
`timescale 1ns/1ps

module pe_zero_gate (
    input  logic                           i_clk,
    input  logic                           i_rstn,
    input  logic                           i_reg_clear,
    input  logic                           i_en,
    input  logic [sa_pe_pkg::A_W-1:0]      i_a,
    input  logic [sa_pe_pkg::B_W-1:0]      i_b,
    input  logic [sa_pe_pkg::TH_W-1:0]     i_thres,
    output logic [sa_pe_pkg::A_W-1:0]      o_a_gated,
    output logic [sa_pe_pkg::B_W-1:0]      o_b_gated,
    output logic                           o_zero
);

    // Per-operand negligence flags
    logic a_negl;
    logic b_negl;
    // Combinational zero detection
    logic zero_d;

    // ------------------------------------------------------------
    // Zero detection with bit negligence
    // ------------------------------------------------------------

    // Operand counts as zero when nothing survives above the
    // lowest i_thres bits; threshold 0 means an exact zero
    assign a_negl = ((i_a >> i_thres) == '0);
    assign b_negl = ((i_b >> i_thres) == '0);

    // One negligible operand makes the whole product negligible
    assign zero_d = a_negl | b_negl;

    // ------------------------------------------------------------
    // Zero flag register
    // ------------------------------------------------------------

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_zero <= 1'b0;
        end else if (i_reg_clear) begin
            o_zero <= 1'b0;
        end else if (i_en) begin
            o_zero <= zero_d;
        end
    end

    // ------------------------------------------------------------
    // Gated operand registers
    // ------------------------------------------------------------

    // Hold old operands on a zero, so the multiplier stays quiet
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_a_gated <= '0;
            o_b_gated <= '0;
        end else if (i_reg_clear) begin
            o_a_gated <= '0;
            o_b_gated <= '0;
        end else if (i_en && !zero_d) begin
            o_a_gated <= i_a;
            o_b_gated <= i_b;
        end
    end

endmodule

// File: hdl/sa_pe_pkg.sv
package sa_pe_pkg;

    // ------------------------------------------------------------
    // Operand and result widths
    // ------------------------------------------------------------

    // Activation operand
    localparam int A_W = 16;
    // Weight operand
    localparam int B_W = 16;
    // Accumulator and output scan chain
    localparam int ACC_W = 48;
    // Bit negligence threshold
    localparam int TH_W = 2;
    // Full signed product
    localparam int PROD_W = A_W + B_W;

    // ------------------------------------------------------------
    // Pipeline depths
    // ------------------------------------------------------------

    // Register stages inside the multiplier
    localparam int MUL_STAGES = 2;
    // Operand capture to accumulator input, in enabled cycles
    // Zero gate stage + multiplier stages + intermediate stage
    localparam int PROD_LATENCY = MUL_STAGES + 2;

endpackage
